/* verilog.f */
+incdir+common
common/cpuPkg.sv
logic/alu.sv
logic/programMemory.sv
datapath/registerFile.sv
datapath/busDatapath.sv
control/controlSequencer.sv
logic/cpuTop.sv
verif/cpuTb_properties.sv
verif/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= cpuTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
SIMARGS   ?= +verilator+error+limit+1000

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/cpuTb.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuTb import cpuPkg::*; ();

	localparam int CLOCK_PERIOD = 100;
	localparam int MAX_PROG_LEN = 12;
	localparam int PROG_COUNT = 27;
	// reset, load, two register sweeps and the hold window.
	localparam int SETUP_CYCLES = 80;
	localparam int TIMEOUT_NS = PROG_COUNT * (6 * MAX_PROG_LEN + 20 + SETUP_CYCLES) * CLOCK_PERIOD;

	logic Clock = 1'b0;
	logic rstN;
	logic run;
	logic loadEn;
	memAddrT loadAddr;
	wordT loadData;
	regIdxT dbgSel;
	logic halted;
	wordT dbgData;

	wordT prog [MAX_PROG_LEN];
	int progLen;
	wordT expRegs [`REG_COUNT];
	int expCycles;
	string progName;
	int errors;
	int checks;
	integer seed;
	event startCheck;
	event checkDone;

	cpuTop cpuTop_i (
		.Clock    (Clock),
		.rstN     (rstN),
		.run      (run),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.dbgSel   (dbgSel),
		.halted   (halted),
		.dbgData  (dbgData)
	);

	always #(CLOCK_PERIOD / 2) Clock = ~Clock;

	function automatic wordT makeRegInstr(input opcodeT op, input regIdxT ra, input regIdxT rb,
		input regIdxT rc);
		return {op, ra, rb, rc, 15'b0};
	endfunction

	function automatic wordT makeImmInstr(input opcodeT op, input regIdxT ra, input regIdxT rb,
		input int c);
		return {op, ra, rb, c[18:0]};
	endfunction

	function automatic opcodeT opcodeByIndex(input logic [2:0] idx);
		case (idx)
			3'd0: return opAdd;
			3'd1: return opSub;
			3'd2: return opAnd;
			3'd3: return opOr;
			3'd4: return opAddi;
			3'd5: return opAndi;
			3'd6: return opOri;
			default: return opHalt;
		endcase
	endfunction

	// expected registers and edge count from run to halted.
	function automatic int refModel(input int len, output wordT regsOut [`REG_COUNT]);
		wordT r [`REG_COUNT];
		wordT instr;
		wordT opB;
		wordT cVal;
		logic [4:0] op;
		regIdxT ra;
		regIdxT rb;
		regIdxT rc;
		int executed;
		int pc;
		logic stop;
		for (int i = 0; i < `REG_COUNT; i++) begin
			r[i] = '0;
		end
		executed = 0;
		pc = 0;
		stop = 1'b0;
		while (!stop && pc < len) begin
			instr = prog[pc];
			op = instr[31:27];
			ra = instr[26:23];
			rb = instr[22:19];
			rc = instr[18:15];
			// C read as a 19-bit two's-complement value.
			cVal = wordT'(instr[18:0]);
			if (instr[18]) begin
				cVal = cVal - 32'h0008_0000;
			end
			opB = (rb == '0) ? '0 : r[rb];
			case (op)
				opAdd: r[ra] = r[rb] + r[rc];
				opSub: r[ra] = r[rb] - r[rc];
				opAnd: r[ra] = r[rb] & r[rc];
				opOr: r[ra] = r[rb] | r[rc];
				opAddi: r[ra] = opB + cVal;
				opAndi: r[ra] = opB & cVal;
				opOri: r[ra] = opB | cVal;
				default: stop = 1'b1;
			endcase
			if (!stop) begin
				executed++;
			end
			pc++;
		end
		regsOut = r;
		return 6 * executed + 3;
	endfunction

	task automatic resetCore();
		@(posedge Clock);
		rstN <= 1'b0;
		run <= 1'b0;
		loadEn <= 1'b0;
		repeat (3) @(posedge Clock);
		rstN <= 1'b1;
	endtask

	task automatic loadProgram();
		for (int i = 0; i < progLen; i++) begin
			@(posedge Clock);
			loadEn <= 1'b1;
			loadAddr <= memAddrT'(i);
			loadData <= prog[i];
		end
		@(posedge Clock);
		loadEn <= 1'b0;
	endtask

	task automatic runProgram(input string name);
		progName = name;
		expCycles = refModel(progLen, expRegs);
		resetCore();
		loadProgram();
		@(posedge Clock);
		run <= 1'b1;
		-> startCheck;
		@(checkDone);
	endtask

	task automatic buildChainProgram(input int n);
		for (int i = 0; i < n; i++) begin
			prog[i] = makeImmInstr(opAddi, regIdxT'(i + 1), regIdxT'(i), i + 1);
		end
		prog[n] = {opHalt, 27'b0};
		progLen = n + 1;
	endtask

	task automatic buildRandomProgram();
		logic [31:0] r;
		int len;
		r = $random(seed);
		len = int'(r[2:0]) + 1;
		for (int i = 0; i < len; i++) begin
			r = $random(seed);
			prog[i] = {opcodeByIndex(r[31:29]), r[26:0]};
		end
		prog[len] = {opHalt, 27'b0};
		progLen = len + 1;
	endtask

	task automatic compareRegisters(input string what);
		for (int i = 0; i < `REG_COUNT; i++) begin
			@(posedge Clock);
			dbgSel <= regIdxT'(i);
			@(negedge Clock);
			checks++;
			assert (dbgData == expRegs[i]) else begin
				errors++;
				$display("Fail at %0t: %s r%0d %s is %h, expected %h", $time, progName, i, what,
					dbgData, expRegs[i]);
			end
		end
	endtask

	// compares the DUT against the model once per program.
	initial begin
		int edges;
		dbgSel = '0;
		forever begin
			@(startCheck);
			if (expCycles < 0) begin
				repeat (10) begin
					@(negedge Clock);
					checks++;
					assert (!halted) else begin
						errors++;
						$display("Fail at %0t: %s halted rose without run", $time, progName);
					end
				end
				compareRegisters("after reset");
			end else begin
				edges = 0;
				@(posedge Clock);
				do begin
					@(posedge Clock);
					edges++;
					@(negedge Clock);
				end while (!halted);
				checks++;
				assert (edges == expCycles) else begin
					errors++;
					$display("Fail at %0t: %s halted after %0d edges, expected %0d", $time,
						progName, edges, expCycles);
				end
				compareRegisters("at halt");
				repeat (20) begin
					@(negedge Clock);
					checks++;
					assert (halted) else begin
						errors++;
						$display("Fail at %0t: %s halted dropped while held", $time, progName);
					end
				end
				compareRegisters("after hold");
			end
			-> checkDone;
		end
	end

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		errors = 0;
		checks = 0;
		seed = 74;
		progLen = 0;

		// idle core after reset.
		progName = "reset";
		resetCore();
		for (int i = 0; i < `REG_COUNT; i++) begin
			expRegs[i] = '0;
		end
		expCycles = -1;
		-> startCheck;
		@(checkDone);

		// r0 is written first, so baOut reads of rb=0 must still give zero.
		prog[0] = makeImmInstr(opAddi, 4'd0, 4'd0, 7);
		prog[1] = makeImmInstr(opAddi, 4'd2, 4'd0, 5);
		prog[2] = makeImmInstr(opAddi, 4'd3, 4'd2, -9);
		prog[3] = makeImmInstr(opAndi, 4'd4, 4'd3, 32'h1F0F0);
		prog[4] = makeImmInstr(opOri, 4'd5, 4'd3, -256);
		prog[5] = makeImmInstr(opOri, 4'd6, 4'd0, 32'h12345);
		prog[6] = makeImmInstr(opAddi, 4'd7, 4'd7, -1);
		prog[7] = makeImmInstr(opAndi, 4'd8, 4'd7, -2);
		prog[8] = {opHalt, 27'b0};
		progLen = 9;
		runProgram("immediate");

		prog[0] = makeImmInstr(opAddi, 4'd1, 4'd0, 1);
		prog[1] = makeImmInstr(opAddi, 4'd2, 4'd0, -1);
		prog[2] = makeRegInstr(opAdd, 4'd3, 4'd2, 4'd1);
		prog[3] = makeRegInstr(opSub, 4'd4, 4'd3, 4'd1);
		prog[4] = makeImmInstr(opAddi, 4'd5, 4'd0, 32'h2AAAA);
		prog[5] = makeRegInstr(opAnd, 4'd6, 4'd5, 4'd4);
		prog[6] = makeRegInstr(opOr, 4'd7, 4'd5, 4'd1);
		prog[7] = makeRegInstr(opAdd, 4'd5, 4'd5, 4'd5);
		prog[8] = makeRegInstr(opSub, 4'd1, 4'd1, 4'd1);
		prog[9] = makeRegInstr(opOr, 4'd0, 4'd5, 4'd0);
		prog[10] = {opHalt, 27'b0};
		progLen = 11;
		runProgram("register");

		buildChainProgram(0);
		runProgram("length 0");
		buildChainProgram(1);
		runProgram("length 1");
		buildChainProgram(4);
		runProgram("length 4");
		buildChainProgram(MAX_PROG_LEN - 1);
		runProgram("length 11");

		for (int p = 0; p < 20; p++) begin
			buildRandomProgram();
			runProgram($sformatf("random %0d", p));
		end

		errors += cpuTop_i.controlSequencer_i.cpuTbProperties_i.failCount;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: halted never rose within %0d ns", TIMEOUT_NS);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* verif/cpuTb_properties.sv */
`timescale 1ns/1ps

module cpuTbProperties import cpuPkg::*; (
	input logic        Clock,
	input logic        rstN,
	input stepT        step,
	input logic        halted,
	input logic [5:0]  busSources,
	input logic [11:0] loadStrobes
);

	int failCount = 0;

	oneBusSource: assert property (@(posedge Clock) disable iff (!rstN)
		$onehot0(busSources))
		else begin
			$error("more than one source drives the bus");
			failCount++;
		end

	// only a reset clears halted.
	haltedHolds: assert property (@(posedge Clock) disable iff (!rstN)
		halted |=> halted)
		else begin
			$error("halted fell without a reset");
			failCount++;
		end

	quietWhenStopped: assert property (@(posedge Clock) disable iff (!rstN)
		(halted || step == stepIdle) |-> (busSources == '0 && loadStrobes == '0))
		else begin
			$error("strobe active while idle or halted");
			failCount++;
		end

endmodule

bind controlSequencer cpuTbProperties cpuTbProperties_i (
	.Clock       (Clock),
	.rstN        (rstN),
	.step        (step),
	.halted      (halted),
	.busSources  ({pcOut, mdrOut, zLowOut, rOut, baOut, cOut}),
	.loadStrobes ({pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn, gra, grb, grc, incPc, read})
);

/* logic/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
	input  logic    Clock,
	input  logic    rstN,
	input  logic    run,
	input  logic    loadEn,
	input  memAddrT loadAddr,
	input  wordT    loadData,
	input  regIdxT  dbgSel,
	output logic    halted,
	output wordT    dbgData
);

	logic pcOut;
	logic mdrOut;
	logic zLowOut;
	logic rOut;
	logic baOut;
	logic cOut;
	logic pcIn;
	logic irIn;
	logic marIn;
	logic mdrIn;
	logic yIn;
	logic zIn;
	logic rIn;
	logic gra;
	logic grb;
	logic grc;
	logic incPc;
	logic read;
	aluOpT aluOp;
	opcodeT opcode;
	memAddrT memAddr;
	wordT memData;

	programMemory programMemory_i (
		.Clock    (Clock),
		.loadEn   (loadEn),
		.loadAddr (loadAddr),
		.loadData (loadData),
		.addr     (memAddr),
		.read     (read),
		.data     (memData)
	);

	controlSequencer controlSequencer_i (
		.Clock   (Clock),
		.rstN    (rstN),
		.run     (run),
		.opcode  (opcode),
		.pcOut   (pcOut),
		.mdrOut  (mdrOut),
		.zLowOut (zLowOut),
		.rOut    (rOut),
		.baOut   (baOut),
		.cOut    (cOut),
		.pcIn    (pcIn),
		.irIn    (irIn),
		.marIn   (marIn),
		.mdrIn   (mdrIn),
		.yIn     (yIn),
		.zIn     (zIn),
		.rIn     (rIn),
		.gra     (gra),
		.grb     (grb),
		.grc     (grc),
		.incPc   (incPc),
		.read    (read),
		.halted  (halted),
		.aluOp   (aluOp)
	);

	busDatapath busDatapath_i (
		.Clock   (Clock),
		.rstN    (rstN),
		.memData (memData),
		.pcOut   (pcOut),
		.mdrOut  (mdrOut),
		.zLowOut (zLowOut),
		.rOut    (rOut),
		.baOut   (baOut),
		.cOut    (cOut),
		.pcIn    (pcIn),
		.irIn    (irIn),
		.marIn   (marIn),
		.mdrIn   (mdrIn),
		.yIn     (yIn),
		.zIn     (zIn),
		.rIn     (rIn),
		.gra     (gra),
		.grb     (grb),
		.grc     (grc),
		.incPc   (incPc),
		.read    (read),
		.aluOp   (aluOp),
		.memAddr (memAddr),
		.opcode  (opcode),
		.dbgSel  (dbgSel),
		.dbgData (dbgData)
	);

endmodule

/* control/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer import cpuPkg::*; (
	input  logic   Clock,
	input  logic   rstN,
	input  logic   run,
	input  opcodeT opcode,
	output logic   pcOut,
	output logic   mdrOut,
	output logic   zLowOut,
	output logic   rOut,
	output logic   baOut,
	output logic   cOut,
	output logic   pcIn,
	output logic   irIn,
	output logic   marIn,
	output logic   mdrIn,
	output logic   yIn,
	output logic   zIn,
	output logic   rIn,
	output logic   gra,
	output logic   grb,
	output logic   grc,
	output logic   incPc,
	output logic   read,
	output logic   halted,
	output aluOpT  aluOp
);

	stepT step;
	stepT stepNext;
	logic isReg;
	logic isImm;
	logic isHalt;
	aluOpT opAlu;

	// opcode class and matching ALU operation.
	always_comb begin
		isReg = 1'b0;
		isImm = 1'b0;
		opAlu = aluAdd;
		case (opcode)
			opAdd: begin
				isReg = 1'b1;
			end
			opSub: begin
				isReg = 1'b1;
				opAlu = aluSub;
			end
			opAnd: begin
				isReg = 1'b1;
				opAlu = aluAnd;
			end
			opOr: begin
				isReg = 1'b1;
				opAlu = aluOr;
			end
			opAddi: begin
				isImm = 1'b1;
			end
			opAndi: begin
				isImm = 1'b1;
				opAlu = aluAnd;
			end
			opOri: begin
				isImm = 1'b1;
				opAlu = aluOr;
			end
			default: begin
				isReg = 1'b0;
			end
		endcase
	end

	// halt and anything unknown stop the core.
	assign isHalt = !(isReg || isImm);

	always_comb begin
		stepNext = step;
		case (step)
			stepIdle: stepNext = run ? stepT0 : stepIdle;
			stepT0: stepNext = stepT1;
			stepT1: stepNext = stepT2;
			stepT2: stepNext = stepT3;
			stepT3: stepNext = isHalt ? stepStopped : stepT4;
			stepT4: stepNext = stepT5;
			stepT5: stepNext = stepT0;
			default: stepNext = stepStopped;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			step <= stepIdle;
		end else begin
			step <= stepNext;
		end
	end

	// halted goes high in the T3 that sees the halt.
	assign halted = (step == stepStopped) || (step == stepT3 && isHalt);

	always_comb begin
		pcOut = 1'b0;
		mdrOut = 1'b0;
		zLowOut = 1'b0;
		rOut = 1'b0;
		baOut = 1'b0;
		cOut = 1'b0;
		pcIn = 1'b0;
		irIn = 1'b0;
		marIn = 1'b0;
		mdrIn = 1'b0;
		yIn = 1'b0;
		zIn = 1'b0;
		rIn = 1'b0;
		gra = 1'b0;
		grb = 1'b0;
		grc = 1'b0;
		incPc = 1'b0;
		read = 1'b0;
		aluOp = aluAdd;
		case (step)
			stepT0: begin
				pcOut = 1'b1;
				marIn = 1'b1;
				incPc = 1'b1;
				zIn = 1'b1;
				aluOp = aluIncr;
			end
			stepT1: begin
				zLowOut = 1'b1;
				pcIn = 1'b1;
				read = 1'b1;
				mdrIn = 1'b1;
			end
			stepT2: begin
				mdrOut = 1'b1;
				irIn = 1'b1;
			end
			stepT3: begin
				// rb into Y, zero-rule read for immediates.
				grb = !isHalt;
				yIn = !isHalt;
				rOut = isReg;
				baOut = isImm;
			end
			stepT4: begin
				zIn = 1'b1;
				aluOp = opAlu;
				grc = isReg;
				rOut = isReg;
				cOut = isImm;
			end
			stepT5: begin
				zLowOut = 1'b1;
				gra = 1'b1;
				rIn = 1'b1;
			end
			default: begin
				aluOp = aluAdd;
			end
		endcase
	end

endmodule

/* datapath/busDatapath.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module busDatapath import cpuPkg::*; (
	input  logic    Clock,
	input  logic    rstN,
	input  wordT    memData,
	input  logic    pcOut,
	input  logic    mdrOut,
	input  logic    zLowOut,
	input  logic    rOut,
	input  logic    baOut,
	input  logic    cOut,
	input  logic    pcIn,
	input  logic    irIn,
	input  logic    marIn,
	input  logic    mdrIn,
	input  logic    yIn,
	input  logic    zIn,
	input  logic    rIn,
	input  logic    gra,
	input  logic    grb,
	input  logic    grc,
	input  logic    incPc,
	input  logic    read,
	input  aluOpT   aluOp,
	output memAddrT memAddr,
	output opcodeT  opcode,
	input  regIdxT  dbgSel,
	output wordT    dbgData
);

	wordT pc;
	wordT ir;
	memAddrT mar;
	wordT mdr;
	wordT y;
	wordT z;
	wordT cSext;
	wordT regOut;
	wordT aluResult;
	wordT busData;

	// C field sign-extended to a full word.
	assign cSext = {{(`WORD_WIDTH-`CONST_WIDTH){ir[`CONST_WIDTH-1]}}, ir[`CONST_WIDTH-1:0]};

	// one source at a time, zero when idle.
	// regOut is already gated inside the register file.
	assign busData = ({`WORD_WIDTH{pcOut}} & pc)
		| ({`WORD_WIDTH{mdrOut}} & mdr)
		| ({`WORD_WIDTH{zLowOut}} & z)
		| ({`WORD_WIDTH{cOut}} & cSext)
		| regOut;

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;
			mar <= '0;
		end else begin
			if (pcIn) begin
				pc <= busData;
			end
			if (irIn) begin
				ir <= busData;
			end
			if (marIn) begin
				mar <= busData[`ADDR_WIDTH-1:0];
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (mdrIn) begin
			mdr <= read ? memData : busData;
		end
		if (yIn) begin
			y <= busData;
		end
		if (zIn) begin
			z <= aluResult;
		end
	end

	assign memAddr = mar;
	assign opcode = opcodeT'(ir[31:27]);

	registerFile registerFile_i (
		.Clock   (Clock),
		.rstN    (rstN),
		.ir      (ir),
		.gra     (gra),
		.grb     (grb),
		.grc     (grc),
		.rIn     (rIn),
		.rOut    (rOut),
		.baOut   (baOut),
		.busIn   (busData),
		.dbgSel  (dbgSel),
		.regOut  (regOut),
		.dbgData (dbgData)
	);

	alu alu_i (
		.a      (y),
		.b      (busData),
		.op     (aluOp),
		.incPc  (incPc),
		.result (aluResult)
	);

endmodule

/* datapath/registerFile.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module registerFile import cpuPkg::*; (
	input  logic   Clock,
	input  logic   rstN,
	input  wordT   ir,
	input  logic   gra,
	input  logic   grb,
	input  logic   grc,
	input  logic   rIn,
	input  logic   rOut,
	input  logic   baOut,
	input  wordT   busIn,
	input  regIdxT dbgSel,
	output wordT   regOut,
	output wordT   dbgData
);

	wordT regs [`REG_COUNT];
	regIdxT sel;

	// field picked by whichever select is up.
	always_comb begin
		if (gra) begin
			sel = ir[26:23];
		end else if (grb) begin
			sel = ir[22:19];
		end else if (grc) begin
			sel = ir[18:15];
		end else begin
			sel = '0;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			regs[sel] <= busIn;
		end
	end

	// baOut reads r0 as zero.
	assign regOut = (rOut || (baOut && sel != '0)) ? regs[sel] : '0;
	assign dbgData = regs[dbgSel];

endmodule

/* logic/programMemory.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module programMemory import cpuPkg::*; (
	input  logic    Clock,
	input  logic    loadEn,
	input  memAddrT loadAddr,
	input  wordT    loadData,
	input  memAddrT addr,
	input  logic    read,
	output wordT    data
);

	wordT mem [`MEM_DEPTH];

	always_ff @(posedge Clock) begin
		if (loadEn) begin
			mem[loadAddr] <= loadData;
		end
	end

	// nothing on the output unless a fetch is under way.
	assign data = read ? mem[addr] : '0;

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import cpuPkg::*; (
	input  wordT  a,
	input  wordT  b,
	input  aluOpT op,
	input  logic  incPc,
	output wordT  result
);

	wordT opResult;

	always_comb begin
		case (op)
			aluAdd: begin
				opResult = a + b;
			end
			aluSub: begin
				opResult = a - b;
			end
			aluAnd: begin
				opResult = a & b;
			end
			aluOr: begin
				opResult = a | b;
			end
			aluIncr: begin
				opResult = b + 1'b1;
			end
			default: begin
				opResult = '0;
			end
		endcase
	end

	// PC increment overrides the operation.
	assign result = incPc ? b + 1'b1 : opResult;

endmodule

/* common/cpuPkg.sv */
`include "cpu_defines.svh"

package cpuPkg;

	// instruction format:
	//   [31:27] opcode, [26:23] ra, [22:19] rb, [18:15] rc.
	//   [18:0] constant C, sign-extended for immediate forms.

	typedef logic [`WORD_WIDTH-1:0] wordT;
	typedef logic [`REG_IDX_WIDTH-1:0] regIdxT;
	typedef logic [`ADDR_WIDTH-1:0] memAddrT;

	typedef enum logic [`OPCODE_WIDTH-1:0] {
		opAdd  = 5'b00011,
		opSub  = 5'b00100,
		opAnd  = 5'b00101,
		opOr   = 5'b00110,
		opAddi = 5'b01100,
		opAndi = 5'b01101,
		opOri  = 5'b01110,
		opHalt = 5'b11011
	} opcodeT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluIncr
	} aluOpT;

	// sequencer steps.
	typedef enum logic [2:0] {
		stepIdle,
		stepT0,
		stepT1,
		stepT2,
		stepT3,
		stepT4,
		stepT5,
		stepStopped
	} stepT;

endpackage

/* common/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data and instruction width.
`define WORD_WIDTH 32

// register file size and index width.
`define REG_COUNT 16
`define REG_IDX_WIDTH 4

// program memory.
`define MEM_DEPTH 64
`define ADDR_WIDTH 6

// instruction fields.
`define OPCODE_WIDTH 5
`define CONST_WIDTH 19

`endif
